// File: hw/trace_pkg.sv
/*
 * trace front end shared definitions
 * widths, window and rule types, FIFO word fields and command codes
 */

package trace_pkg;

   ////////////////////
   // sizes
   localparam int WINDOW_BITS     = 64;
   localparam int N_RULES         = 4;
   localparam int COUNT_BITS      = 8;
   localparam int SHORT_TIME_BITS = 8;
   localparam int FULL_TIME_BITS  = 16;
   localparam int FIFO_BITS       = 18;

   // fifo word field positions
   localparam int CMD_LSB  = 16;
   localparam int TIME_LSB = 8;

   // sync frame signature, newest 16 and oldest 8 window bits
   localparam logic [15:0] SYNC_HEAD = 16'h7fff;
   localparam logic [7:0]  SYNC_TAIL = 8'hff;

   ////////////////////
   // plain vectors
   // window bit 0 is the oldest bit received
   typedef logic [WINDOW_BITS-1:0]     trace_word_t;
   typedef logic [N_RULES-1:0]         rule_vec_t;
   typedef logic [COUNT_BITS-1:0]      hit_count_t;
   typedef logic [SHORT_TIME_BITS-1:0] short_time_t;
   typedef logic [FULL_TIME_BITS-1:0]  full_time_t;
   typedef logic [FIFO_BITS-1:0]       fifo_word_t;

   ////////////////////
   // encodings
   typedef enum logic [2:0] {width_1 = 3'd1, width_2 = 3'd2, width_4 = 3'd4} trace_width_e;
   // cmd_stat reserved, not formatted here
   typedef enum logic [1:0] {cmd_data = 2'd0, cmd_stat = 2'd1, cmd_time = 2'd2} fifo_cmd_e;
   typedef enum logic {hunting, locked} sync_state_e;

   ////////////////////
   // grouped signals
   typedef struct packed {trace_word_t pattern; trace_word_t mask;} match_rule_t;
   typedef match_rule_t [N_RULES-1:0] rule_set_t;
   typedef struct packed {rule_vec_t pattern_enable; rule_vec_t trig_enable;} rule_ctrl_t;
   // one capture FIFO write request
   typedef struct packed {
      logic       wr;
      fifo_cmd_e  cmd;
      full_time_t time_val;
   } fifo_req_t;

endpackage

// File: hw/trace_shifter.sv
/*
 * trace pin deserializer
 * shifts 1, 2 or 4 pins (single or double sampled) into the 64-bit window
 */

`timescale 1ns/10ps

module trace_shifter (
   input  logic                      fe_clk,
   input  logic                      reset,
   input  logic [7:0]                trace_data,
   input  logic                      trace_clock_sel,
   input  trace_pkg::trace_width_e   trace_width,
   output trace_pkg::trace_word_t    window
);

   localparam int TOP = trace_pkg::WINDOW_BITS - 1;

   trace_pkg::trace_word_t shifted;

   ////////////////////
   // next window
   // new bits enter at the top, pin 0 oldest within a cycle
   // clock_sel high takes the second sample set on pins 4..7
   always_comb begin
      case (trace_width)
         trace_pkg::width_4: begin
            if (trace_clock_sel)
               shifted = {trace_data[7:0], window[TOP:8]};
            else
               shifted = {trace_data[3:0], window[TOP:4]};
         end
         trace_pkg::width_2: begin
            if (trace_clock_sel)
               shifted = {trace_data[5:4], trace_data[1:0], window[TOP:4]};
            else
               shifted = {trace_data[1:0], window[TOP:2]};
         end
         // width 1, also any unsupported code
         default: begin
            if (trace_clock_sel)
               shifted = {trace_data[4], trace_data[0], window[TOP:2]};
            else
               shifted = {trace_data[0], window[TOP:1]};
         end
      endcase
   end

   // window register
   always_ff @(posedge fe_clk) begin
      if (reset)
         window <= '0;
      else
         window <= shifted;
   end

endmodule

// File: hw/trace_sync.sv
/*
 * trace sync frame lock
 * hunts for a sync frame in the window, then tracks byte alignment
 * and strobes window_valid on each aligned window
 */

`timescale 1ns/10ps

module trace_sync (
   input  logic                      fe_clk,
   input  logic                      reset,
   input  trace_pkg::trace_word_t    window,
   input  trace_pkg::trace_width_e   trace_width,
   input  logic                      trace_clock_sel,
   input  logic                      resync,
   output logic                      synchronized,
   output logic                      window_valid
);

   trace_pkg::sync_state_e  state;
   trace_pkg::trace_width_e width_q;
   logic [2:0]              align_count;
   logic                    frame_seen;
   logic                    width_changed;

   // newest bits hold the sync head, oldest byte all ones
   assign frame_seen = (window[trace_pkg::WINDOW_BITS-1 -: 16] == trace_pkg::SYNC_HEAD) &&
                       (window[7:0] == trace_pkg::SYNC_TAIL);
   assign width_changed = (trace_width != width_q);

   ////////////////////
   // lock FSM
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         state       <= trace_pkg::hunting;
         width_q     <= trace_pkg::width_1;
         align_count <= '0;
      end else begin
         width_q <= trace_width;
         // forced relock wins over a new lock
         if (resync || width_changed) begin
            state       <= trace_pkg::hunting;
            align_count <= '0;
         end else if (state == trace_pkg::hunting && frame_seen) begin
            state       <= trace_pkg::locked;
            align_count <= 3'd1;
         end else if (state == trace_pkg::locked) begin
            // wraps every 8 cycles
            align_count <= align_count + 3'd1;
         end
      end
   end

   assign synchronized = (state == trace_pkg::locked);

   ////////////////////
   // byte alignment strobe
   // period in cycles is 8/w, halved when double sampled
   always_comb begin
      window_valid = 1'b0;
      if (state == trace_pkg::locked) begin
         case (trace_width)
            trace_pkg::width_1:
               window_valid = trace_clock_sel ? (align_count[1:0] == 2'd0) : (align_count == 3'd0);
            trace_pkg::width_2:
               window_valid = trace_clock_sel ? !align_count[0] : (align_count[1:0] == 2'd0);
            trace_pkg::width_4:
               window_valid = trace_clock_sel ? 1'b1 : !align_count[0];
            default:
               window_valid = 1'b0;
         endcase
      end
   end

   // no aligned window until a sync frame has locked us
   assert property (@(posedge fe_clk) disable iff (reset)
      window_valid |-> state == trace_pkg::locked);

endmodule

// File: hw/pattern_matcher.sv
/*
 * masked pattern rules and trigger
 * compares four rules against each aligned window, counts hits,
 * keeps the last hit vector and raises trigger_match on edges
 */

`timescale 1ns/10ps

module pattern_matcher (
   input  logic                      fe_clk,
   input  logic                      reset,
   input  trace_pkg::trace_word_t    window,
   input  logic                      window_valid,
   input  trace_pkg::rule_set_t      rules,
   input  trace_pkg::rule_ctrl_t     rule_ctrl,
   input  logic                      capturing,
   input  logic                      arm,
   input  logic                      soft_trig_enable,
   input  logic                      ext_trig,
   input  logic                      capture_now,
   output logic                      match_event,
   output logic                      trigger_match,
   output trace_pkg::hit_count_t [trace_pkg::N_RULES-1:0] hit_counts,
   output trace_pkg::rule_vec_t      last_rule
);

   trace_pkg::rule_vec_t hit;
   trace_pkg::rule_vec_t trig_hit;
   logic                 capturing_q;
   logic                 ext_trig_q;
   logic                 trig_any_q;
   logic                 ext_rise;
   logic                 trig_rise;

   ////////////////////
   // rule compare
   // trig-enabled rules still hit while not capturing, so they can trigger
   always_comb begin
      for (int i = 0; i < trace_pkg::N_RULES; i++) begin
         hit[i] = ((window & rules[i].mask) == (rules[i].pattern & rules[i].mask)) &&
                  rule_ctrl.pattern_enable[i] && window_valid &&
                  (capturing_q || rule_ctrl.trig_enable[i]);
      end
   end

   assign match_event = |hit;
   assign trig_hit    = hit & rule_ctrl.trig_enable;

   ////////////////////
   // trigger
   // rising edges only
   assign ext_rise  = ext_trig && !ext_trig_q && soft_trig_enable;
   assign trig_rise = (|trig_hit) && !trig_any_q;
   // capture_now bypasses arm
   assign trigger_match = capture_now || (arm && (ext_rise || trig_rise));

   // edge history and capturing qualifier
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         capturing_q <= 1'b0;
         ext_trig_q  <= 1'b0;
         trig_any_q  <= 1'b0;
      end else begin
         capturing_q <= capturing;
         ext_trig_q  <= ext_trig;
         trig_any_q  <= |trig_hit;
      end
   end

   ////////////////////
   // hit counters and last rule
   always_ff @(posedge fe_clk) begin
      if (reset) begin
         hit_counts <= '0;
         last_rule  <= '0;
      end else begin
         for (int i = 0; i < trace_pkg::N_RULES; i++) begin
            // free running, wraps at 255
            if (hit[i])
               hit_counts[i] <= hit_counts[i] + 1'b1;
         end
         if (match_event)
            last_rule <= hit;
      end
   end

   // hits only land on byte-aligned windows from trace_sync
   assert property (@(posedge fe_clk) disable iff (reset)
      match_event |-> window_valid);

endmodule

// File: hw/fifo_formatter.sv
/*
 * capture FIFO word formatter
 * registers one 18-bit word per request, cmd in the top two bits
 */

`timescale 1ns/10ps

module fifo_formatter (
   input  logic                      fe_clk,
   input  logic                      reset,
   input  trace_pkg::fifo_req_t      fifo_req,
   input  trace_pkg::rule_vec_t      last_rule,
   output trace_pkg::fifo_word_t     fifo_data,
   output logic                      fifo_wr
);

   trace_pkg::fifo_word_t  word;
   trace_pkg::short_time_t short_time;

   assign short_time = fifo_req.time_val[trace_pkg::SHORT_TIME_BITS-1:0];

   ////////////////////
   // field packing
   always_comb begin
      word = '0;
      word[trace_pkg::CMD_LSB +: 2] = fifo_req.cmd;
      if (fifo_req.cmd == trace_pkg::cmd_data) begin
         // short time over the rule vector, bits 7:4 stay zero
         word[trace_pkg::TIME_LSB +: trace_pkg::SHORT_TIME_BITS] = short_time;
         word[trace_pkg::N_RULES-1:0] = last_rule;
      end else if (fifo_req.cmd == trace_pkg::cmd_time) begin
         word[trace_pkg::FULL_TIME_BITS-1:0] = fifo_req.time_val;
      end
   end

   // write strobe, one per request
   always_ff @(posedge fe_clk) begin
      if (reset)
         fifo_wr <= 1'b0;
      else
         fifo_wr <= fifo_req.wr;
   end

   // data word
   always_ff @(posedge fe_clk) begin
      if (fifo_req.wr)
         fifo_data <= word;
   end

   // every write traces back to a request one cycle earlier
   assert property (@(posedge fe_clk) disable iff (reset)
      fifo_wr |-> $past(fifo_req.wr));

endmodule

// File: hw/trace_frontend.sv
/*
 * parallel trace port front end
 * deserializer, sync lock, pattern matcher and FIFO word formatter
 */

`timescale 1ns/10ps

module trace_frontend (
   input  logic                      fe_clk,
   input  logic                      reset,
   input  logic [7:0]                trace_data,
   input  logic                      trace_clock_sel,
   input  trace_pkg::trace_width_e   trace_width,
   input  logic                      resync,
   input  logic                      capturing,
   input  trace_pkg::rule_set_t      rules,
   input  trace_pkg::rule_ctrl_t     rule_ctrl,
   input  logic                      arm,
   input  logic                      soft_trig_enable,
   input  logic                      ext_trig,
   input  logic                      capture_now,
   input  trace_pkg::fifo_req_t      fifo_req,
   output logic                      synchronized,
   output logic                      match_event,
   output logic                      trigger_match,
   output trace_pkg::hit_count_t [trace_pkg::N_RULES-1:0] hit_counts,
   output trace_pkg::fifo_word_t     fifo_data,
   output logic                      fifo_wr
);

   trace_pkg::trace_word_t window;
   trace_pkg::rule_vec_t   last_rule;
   logic                   window_valid;

   ////////////////////
   // pins to window
   trace_shifter trace_shifter_i (
      .fe_clk          (fe_clk),
      .reset           (reset),
      .trace_data      (trace_data),
      .trace_clock_sel (trace_clock_sel),
      .trace_width     (trace_width),
      .window          (window)
   );

   // alignment
   trace_sync trace_sync_i (
      .fe_clk          (fe_clk),
      .reset           (reset),
      .window          (window),
      .trace_width     (trace_width),
      .trace_clock_sel (trace_clock_sel),
      .resync          (resync),
      .synchronized    (synchronized),
      .window_valid    (window_valid)
   );

   ////////////////////
   // consumers
   pattern_matcher pattern_matcher_i (
      .fe_clk           (fe_clk),
      .reset            (reset),
      .window           (window),
      .window_valid     (window_valid),
      .rules            (rules),
      .rule_ctrl        (rule_ctrl),
      .capturing        (capturing),
      .arm              (arm),
      .soft_trig_enable (soft_trig_enable),
      .ext_trig         (ext_trig),
      .capture_now      (capture_now),
      .match_event      (match_event),
      .trigger_match    (trigger_match),
      .hit_counts       (hit_counts),
      .last_rule        (last_rule)
   );

   fifo_formatter fifo_formatter_i (
      .fe_clk    (fe_clk),
      .reset     (reset),
      .fifo_req  (fifo_req),
      .last_rule (last_rule),
      .fifo_data (fifo_data),
      .fifo_wr   (fifo_wr)
   );

endmodule

// File: sim/trace_frontend_checks.sv
/*
 * trace front end checker
 * reference model of window, sync lock, valid cadence, rule hits,
 * trigger and FIFO words, compared with the DUT by concurrent assertions
 */

`timescale 1ns/10ps

module trace_frontend_checks (
   input  logic                      fe_clk,
   input  logic                      reset,
   input  logic [7:0]                trace_data,
   input  logic                      trace_clock_sel,
   input  trace_pkg::trace_width_e   trace_width,
   input  logic                      resync,
   input  logic                      capturing,
   input  trace_pkg::rule_set_t      rules,
   input  trace_pkg::rule_ctrl_t     rule_ctrl,
   input  logic                      arm,
   input  logic                      soft_trig_enable,
   input  logic                      ext_trig,
   input  logic                      capture_now,
   input  trace_pkg::fifo_req_t      fifo_req,
   input  logic                      synchronized,
   input  logic                      match_event,
   input  logic                      trigger_match,
   input  trace_pkg::hit_count_t [trace_pkg::N_RULES-1:0] hit_counts,
   input  trace_pkg::fifo_word_t     fifo_data,
   input  logic                      fifo_wr,
   output int                        check_errors
);

   trace_pkg::trace_word_t  model_window;
   trace_pkg::trace_width_e width_q;
   trace_pkg::rule_vec_t    model_hit;
   trace_pkg::rule_vec_t    model_last;
   trace_pkg::hit_count_t [trace_pkg::N_RULES-1:0] model_counts;
   trace_pkg::fifo_word_t   exp_word;
   logic [2:0]              model_count;
   logic                    model_locked;
   logic                    model_valid;
   logic                    model_trig;
   logic                    frame;
   logic                    capturing_q;
   logic                    ext_q;
   logic                    trig_q;
   logic                    exp_wr;
   int                      period;

   initial check_errors = 0;

   task automatic value_error(input string name, input logic [63:0] want,
                              input logic [63:0] got);
      check_errors++;
      $display("FAILED %0t %s expected %0h got %0h", $time, name, want, got);
   endtask

   task automatic state_error(input string what);
      check_errors++;
      $display("at %0t %s", $time, what);
   endtask

   // pins in arrival order, sample set 2 from pin 4 up
   function automatic trace_pkg::trace_word_t shift_in(trace_pkg::trace_word_t win,
         logic [7:0] pins, logic dbl, trace_pkg::trace_width_e wd);
      int w;
      int pin;
      trace_pkg::trace_word_t r;
      w = int'(wd);
      r = win;
      for (int k = 0; k < (dbl ? 2 * w : w); k++) begin
         pin = (k < w) ? k : k - w + 4;
         r = {pins[pin], r[trace_pkg::WINDOW_BITS-1:1]};
      end
      return r;
   endfunction

   ////////////////////
   // lock and cadence model
   assign frame = (model_window[63:48] == trace_pkg::SYNC_HEAD) &&
                  (model_window[7:0] == trace_pkg::SYNC_TAIL);

   always_comb begin
      // cycles per aligned byte
      period = (trace_clock_sel ? 4 : 8) / int'(trace_width);
      model_valid = model_locked && (int'(model_count) % period == 0);
      for (int i = 0; i < trace_pkg::N_RULES; i++) begin
         model_hit[i] = ((model_window & rules[i].mask) == (rules[i].pattern & rules[i].mask))
                        && rule_ctrl.pattern_enable[i] && model_valid
                        && (capturing_q || rule_ctrl.trig_enable[i]);
      end
   end

   assign model_trig = capture_now ||
                       (arm && ((soft_trig_enable && ext_trig && !ext_q) ||
                                ((|(model_hit & rule_ctrl.trig_enable)) && !trig_q)));

   always_ff @(posedge fe_clk) begin
      width_q <= trace_width;
      if (reset) begin
         model_window <= '0;
         model_locked <= 1'b0;
         model_count  <= '0;
         model_counts <= '0;
         model_last   <= '0;
         capturing_q  <= 1'b0;
         ext_q        <= 1'b0;
         trig_q       <= 1'b0;
         exp_wr       <= 1'b0;
      end else begin
         model_window <= shift_in(model_window, trace_data, trace_clock_sel, trace_width);
         // resync or width change beats a fresh lock
         if (resync || trace_width != width_q) begin
            model_locked <= 1'b0;
            model_count  <= '0;
         end else if (!model_locked && frame) begin
            model_locked <= 1'b1;
            model_count  <= 3'd1;
         end else if (model_locked) begin
            model_count <= model_count + 3'd1;
         end
         for (int i = 0; i < trace_pkg::N_RULES; i++) begin
            if (model_hit[i])
               model_counts[i] <= model_counts[i] + 8'd1;
         end
         if (|model_hit)
            model_last <= model_hit;
         capturing_q <= capturing;
         ext_q       <= ext_trig;
         trig_q      <= |(model_hit & rule_ctrl.trig_enable);
         exp_wr      <= fifo_req.wr;
      end
   end

   ////////////////////
   // expected FIFO word, last rule as seen at the request edge
   always_ff @(posedge fe_clk) begin
      if (fifo_req.wr) begin
         case (fifo_req.cmd)
            trace_pkg::cmd_data:
               exp_word <= {fifo_req.cmd, fifo_req.time_val[7:0], 4'h0, model_last};
            trace_pkg::cmd_time:
               exp_word <= {fifo_req.cmd, fifo_req.time_val};
            default:
               exp_word <= {fifo_req.cmd, 16'h0};
         endcase
      end
   end

   ////////////////////
   // checks
   assert property (@(posedge fe_clk) $fell(reset) |->
         !fifo_wr && !synchronized && !match_event && !trigger_match && hit_counts == '0)
      else state_error("outputs were not idle in the first cycle after reset");

   assert property (@(posedge fe_clk) disable iff (reset) synchronized == model_locked)
      else value_error("synchronized", 64'($sampled(model_locked)), 64'($sampled(synchronized)));

   assert property (@(posedge fe_clk) disable iff (reset) match_event == |model_hit)
      else value_error("match_event", 64'($sampled(|model_hit)), 64'($sampled(match_event)));

   assert property (@(posedge fe_clk) disable iff (reset) hit_counts == model_counts)
      else value_error("hit_counts", 64'($sampled(model_counts)), 64'($sampled(hit_counts)));

   assert property (@(posedge fe_clk) disable iff (reset) trigger_match == model_trig)
      else value_error("trigger_match", 64'($sampled(model_trig)), 64'($sampled(trigger_match)));

   assert property (@(posedge fe_clk) disable iff (reset) fifo_wr == exp_wr)
      else value_error("fifo_wr", 64'($sampled(exp_wr)), 64'($sampled(fifo_wr)));

   assert property (@(posedge fe_clk) disable iff (reset) exp_wr |-> fifo_data == exp_word)
      else value_error("fifo_data", 64'($sampled(exp_word)), 64'($sampled(fifo_data)));

endmodule

// File: sim/trace_frontend_tb.sv
/*
 * trace front end testbench
 * drives sync frames, rule traffic, triggers and FIFO requests,
 * the checker instance does the comparing
 */

`timescale 1ns/10ps

module trace_frontend_tb;

   // per width and clock mode pass of the sync test
   localparam int sync_cycles = 300;
   localparam int test_cycles = 20 + 6 * sync_cycles + 300 + 300 + 100;

   logic                      fe_clk;
   logic                      reset;
   logic [7:0]                trace_data;
   logic                      trace_clock_sel;
   trace_pkg::trace_width_e   trace_width;
   logic                      resync;
   logic                      capturing;
   trace_pkg::rule_set_t      rules;
   trace_pkg::rule_ctrl_t     rule_ctrl;
   logic                      arm;
   logic                      soft_trig_enable;
   logic                      ext_trig;
   logic                      capture_now;
   trace_pkg::fifo_req_t      fifo_req;
   logic                      synchronized;
   logic                      match_event;
   logic                      trigger_match;
   trace_pkg::hit_count_t [trace_pkg::N_RULES-1:0] hit_counts;
   trace_pkg::fifo_word_t     fifo_data;
   logic                      fifo_wr;
   int                        check_errors;
   int                        missed_waits;
   int                        tests_done;
   logic [15:0]               lfsr;
   trace_pkg::trace_width_e   widths [3] = '{trace_pkg::width_1, trace_pkg::width_2,
                                             trace_pkg::width_4};

   trace_frontend trace_frontend_i (.*);
   trace_frontend_checks checks_i (.*);

   initial begin
      fe_clk = 1'b0;
      forever #2 fe_clk = ~fe_clk;
   end

   // galois LFSR, one step per bit
   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[62:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      end
      return v;
   endfunction

   // mostly the rule byte, sometimes noise
   function automatic logic [7:0] traffic_byte();
      if (rand_bits(2) != 64'd0)
         return 8'h66;
      return 8'(rand_bits(8));
   endfunction

   ////////////////////
   // stimulus tasks
   // oldest bit first, spread over the pins of the current mode
   task automatic feed_bits(input logic [63:0] bits, input int nbits);
      int w;
      int b;
      logic [7:0] d;
      w = int'(trace_width);
      b = trace_clock_sel ? 2 * w : w;
      for (int c = 0; c < nbits / b; c++) begin
         @(negedge fe_clk);
         d = '0;
         for (int k = 0; k < b; k++)
            d[(k < w) ? k : k - w + 4] = bits[c * b + k];
         trace_data = d;
      end
   endtask

   task automatic pulse_resync();
      @(negedge fe_clk);
      resync = 1'b1;
      @(negedge fe_clk);
      resync = 1'b0;
   endtask

   task automatic wait_sync(input logic want, input int limit);
      int n;
      n = 0;
      while (synchronized !== want && n < limit) begin
         @(negedge fe_clk);
         n++;
      end
      if (synchronized !== want) begin
         missed_waits++;
         $display("at %0t synchronized did not reach %0b within %0d cycles", $time, want, limit);
      end
   endtask

   // noise, then a full sync frame in the window
   task automatic lock_on();
      logic [63:0] noise;
      pulse_resync();
      feed_bits(rand_bits(32), 32);
      noise = rand_bits(40);
      feed_bits({16'h7fff, noise[39:0], 8'hff}, 64);
      wait_sync(1'b1, 16);
   endtask

   task automatic end_test(input string name);
      tests_done++;
      $display("test %s finished at %0t, %0d errors so far", name, $time,
               check_errors + missed_waits);
   endtask

   ////////////////////
   // test sequence
   initial begin
      reset = 1'b1;
      trace_data = '0;
      trace_clock_sel = 1'b0;
      trace_width = trace_pkg::width_4;
      resync = 1'b0;
      capturing = 1'b0;
      rules = '0;
      rule_ctrl = '0;
      arm = 1'b0;
      soft_trig_enable = 1'b0;
      ext_trig = 1'b0;
      capture_now = 1'b0;
      fifo_req = '0;
      missed_waits = 0;
      tests_done = 0;
      lfsr = 16'd1837;
      repeat (16) @(negedge fe_clk);
      reset = 1'b0;
      repeat (4) @(negedge fe_clk);
      end_test("reset_state");

      // every width in both clock modes, lose lock by resync or width change
      for (int cs = 0; cs < 2; cs++) begin
         for (int wi = 0; wi < 3; wi++) begin
            @(negedge fe_clk);
            trace_clock_sel = cs[0];
            trace_width = widths[wi];
            lock_on();
            feed_bits(rand_bits(64), 64);
            if (wi[0]) begin
               pulse_resync();
            end else begin
               @(negedge fe_clk);
               trace_width = widths[(wi + 1) % 3];
            end
            wait_sync(1'b0, 4);
         end
      end
      end_test("sync_lock");

      // rule 0 under a partial mask, then with capturing low
      @(negedge fe_clk);
      trace_width = trace_pkg::width_4;
      trace_clock_sel = 1'b0;
      rules[0].pattern = {8{8'h66}};
      rules[0].mask = 64'h0000_ffff_0000_0ff0;
      rule_ctrl.pattern_enable = 4'b0001;
      capturing = 1'b1;
      lock_on();
      repeat (40) feed_bits(64'(traffic_byte()), 8);
      capturing = 1'b0;
      repeat (20) feed_bits(64'(traffic_byte()), 8);
      end_test("valid_count");

      // trig-enabled rule, ext edge and capture_now, armed then disarmed
      rules[1].pattern = {8{8'h66}};
      rules[1].mask = 64'hff00_0000_0000_00ff;
      rule_ctrl.pattern_enable = 4'b0010;
      rule_ctrl.trig_enable = 4'b0010;
      for (int a = 1; a >= 0; a--) begin
         arm = a[0];
         repeat (4) feed_bits(64'h33, 8);
         repeat (6) feed_bits(64'(traffic_byte()), 8);
         @(negedge fe_clk);
         soft_trig_enable = 1'b1;
         ext_trig = 1'b1;
         repeat (3) @(negedge fe_clk);
         ext_trig = 1'b0;
         @(negedge fe_clk);
         capture_now = 1'b1;
         @(negedge fe_clk);
         capture_now = 1'b0;
      end
      soft_trig_enable = 1'b0;
      end_test("trigger");

      // back-to-back data and time commands while rules keep hitting
      rule_ctrl.pattern_enable = 4'b0011;
      capturing = 1'b1;
      for (int k = 0; k < 12; k++) begin
         @(negedge fe_clk);
         trace_data = traffic_byte();
         fifo_req.wr = 1'b1;
         fifo_req.cmd = k[0] ? trace_pkg::cmd_time : trace_pkg::cmd_data;
         fifo_req.time_val = 16'(rand_bits(16));
      end
      @(negedge fe_clk);
      fifo_req.wr = 1'b0;
      repeat (4) @(negedge fe_clk);
      end_test("fifo_format");

      $display("tests run %0d, check failures %0d, missed waits %0d",
               tests_done, check_errors, missed_waits);
      if (check_errors == 0 && missed_waits == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

   // watchdog, twice the expected run length
   initial begin
      #(2 * test_cycles * 4);
      $display("watchdog expired after %0d cycles, test sequence did not finish",
               2 * test_cycles);
      $display("Errors found");
      $finish;
   end

endmodule

// File: files.f
hw/trace_pkg.sv
hw/trace_shifter.sv
hw/trace_sync.sv
hw/pattern_matcher.sv
hw/fifo_formatter.sv
hw/trace_frontend.sv
sim/trace_frontend_checks.sv
sim/trace_frontend_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module trace_frontend_tb -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
